//--- lsp_pkg.sv
package lsp_pkg;

	// -------------------------------------------------------------------
	// Fixed-point format and constants
	// -------------------------------------------------------------------
	localparam int FIX_W      = 32;           // Sign + 7 int + 24 frac
	localparam int MAG_W      = FIX_W - 1;    // Magnitude field width
	localparam int FRAC_BITS  = 24;
	localparam int ORDER      = 10;           // LPC order
	localparam int HALF_ORDER = ORDER / 2;    // Highest Chebyshev term

	typedef logic [FIX_W-1:0] fix_t;          // Sign-magnitude word

	localparam fix_t FIX_ONE     = 32'h0100_0000;
	localparam fix_t FIX_NEG_ONE = 32'h8100_0000;
	localparam fix_t FIX_ZERO    = 32'h0000_0000;

	// -------------------------------------------------------------------
	// Bundles
	// -------------------------------------------------------------------
	typedef struct packed {
		fix_t a0;                             // Always +1 for a real frame
		fix_t a1;
		fix_t a2;
		fix_t a3;
		fix_t a4;
		fix_t a5;
		fix_t a6;
		fix_t a7;
		fix_t a8;
		fix_t a9;
		fix_t a10;
	} lpc_coeffs_t;

	// Highest power first, c5 is the constant term
	typedef struct packed {
		fix_t c0;
		fix_t c1;
		fix_t c2;
		fix_t c3;
		fix_t c4;
		fix_t c5;
	} cheb_coeffs_t;

	typedef struct packed {
		cheb_coeffs_t p;                      // Sum polynomial
		cheb_coeffs_t q;                      // Difference polynomial
	} pq_coeffs_t;

	typedef struct packed {
		fix_t lsp0;                           // Closest to +1
		fix_t lsp1;
		fix_t lsp2;
		fix_t lsp3;
		fix_t lsp4;
		fix_t lsp5;
		fix_t lsp6;
		fix_t lsp7;
		fix_t lsp8;
		fix_t lsp9;
	} lsp_vec_t;

	// -------------------------------------------------------------------
	// Sign-magnitude arithmetic
	// -------------------------------------------------------------------
	// Negative zero folded to plain zero
	function automatic fix_t fix_norm(input fix_t a);
		return (a[MAG_W-1:0] == '0) ? FIX_ZERO : a;
	endfunction

	function automatic fix_t fix_add(input fix_t a, input fix_t b);
		logic [MAG_W-1:0] ma;
		logic [MAG_W-1:0] mb;
		fix_t r;
		ma = a[MAG_W-1:0];
		mb = b[MAG_W-1:0];
		if (a[MAG_W] == b[MAG_W])
			r = {a[MAG_W], ma + mb};          // Same sign, magnitudes add
		else if (ma >= mb)
			r = {a[MAG_W], ma - mb};          // a dominates
		else
			r = {b[MAG_W], mb - ma};
		return fix_norm(r);
	endfunction

	function automatic fix_t fix_neg(input fix_t a);
		return fix_norm({~a[MAG_W], a[MAG_W-1:0]});
	endfunction

	function automatic fix_t fix_mul(input fix_t a, input fix_t b);
		logic [2*MAG_W-1:0] ma;
		logic [2*MAG_W-1:0] mb;
		logic [2*MAG_W-1:0] prod;
		ma = a[MAG_W-1:0];                    // Zero extended
		mb = b[MAG_W-1:0];
		prod = ma * mb;
		return fix_norm({a[MAG_W] ^ b[MAG_W], prod[FRAC_BITS +: MAG_W]}); // Truncate
	endfunction

	function automatic fix_t fix_half(input fix_t a);
		return fix_norm({a[MAG_W], a[MAG_W-1:0] >> 1});
	endfunction

	function automatic fix_t fix_double(input fix_t a);
		return {a[MAG_W], a[MAG_W-2:0], 1'b0};
	endfunction

	// Product of the two would be <= 0
	function automatic logic fix_sign_differs(input fix_t a, input fix_t b);
		return (a[MAG_W-1:0] == '0) || (a[MAG_W] != b[MAG_W]);
	endfunction

endpackage

//--- pq_builder.sv
`timescale 1ns/1ps

module pq_builder (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 start,
	input  lsp_pkg::lpc_coeffs_t lpc,
	output lsp_pkg::pq_coeffs_t  pq,
	output logic                 pq_valid
);

	localparam logic [2:0] LAST_STEP = 3'(lsp_pkg::HALF_ORDER + 1); // Doubling step

	lsp_pkg::fix_t [0:lsp_pkg::ORDER]      a;     // a0..a10 by index
	lsp_pkg::fix_t [0:lsp_pkg::HALF_ORDER] p_t;   // Working P terms
	lsp_pkg::fix_t [0:lsp_pkg::HALF_ORDER] q_t;   // Working Q terms
	lsp_pkg::fix_t [0:lsp_pkg::HALF_ORDER] p_d;   // Doubled copies
	lsp_pkg::fix_t [0:lsp_pkg::HALF_ORDER] q_d;
	lsp_pkg::fix_t lo;                            // a[i]
	lsp_pkg::fix_t hi;                            // a[11-i]
	lsp_pkg::fix_t p_new;
	lsp_pkg::fix_t q_new;
	logic [2:0]    step;
	logic          busy;
	logic          go;
	logic          fin;

	assign a   = lpc;
	assign go  = start && !busy;                  // Start while busy is dropped
	assign fin = busy && (step == LAST_STEP);

	// Outer pair of the current step
	assign lo = a[step];
	assign hi = a[4'(lsp_pkg::ORDER + 1) - 4'(step)];

	// P(i) = a(i) + a(11-i) - P(i-1)
	assign p_new = lsp_pkg::fix_add(lsp_pkg::fix_add(lo, hi),
		lsp_pkg::fix_neg(p_t[step - 3'd1]));
	// Q(i) = a(i) - a(11-i) + Q(i-1)
	assign q_new = lsp_pkg::fix_add(lsp_pkg::fix_add(lo, lsp_pkg::fix_neg(hi)),
		q_t[step - 3'd1]);

	// Terms c0..c4 doubled, constant term kept
	always_comb
	begin
		p_d = p_t;
		q_d = q_t;
		for (int i = 0; i < lsp_pkg::HALF_ORDER; i++)
		begin
			p_d[i] = lsp_pkg::fix_double(p_t[i]);
			q_d[i] = lsp_pkg::fix_double(q_t[i]);
		end
	end

	// -------------------------------------------------------------------
	// Step counter: 1..5 recursion, 6 doubling
	// -------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			busy     <= 1'b0;
			step     <= 3'd0;
			pq_valid <= 1'b0;
		end
		else
		begin
			pq_valid <= fin;                      // Lands 7 cycles after start
			if (go)
			begin
				busy <= 1'b1;
				step <= 3'd1;
			end
			else if (fin)
			begin
				busy <= 1'b0;
				step <= 3'd0;
			end
			else if (busy)
				step <= step + 3'd1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (go)
		begin
			p_t[0] <= lsp_pkg::FIX_ONE;           // Leading term of both sets
			q_t[0] <= lsp_pkg::FIX_ONE;
		end
		else if (fin)
		begin
			pq.p <= p_d;                          // Output only moves here
			pq.q <= q_d;
		end
		else if (busy)
		begin
			p_t[step] <= p_new;
			q_t[step] <= q_new;
		end
	end

endmodule

//--- cheb_eval.sv
`timescale 1ns/1ps

module cheb_eval (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  eval_start,
	input  lsp_pkg::fix_t         eval_x,
	input  lsp_pkg::cheb_coeffs_t eval_coeffs,
	output lsp_pkg::fix_t         eval_sum,
	output logic                  eval_done
);

	// Clenshaw form of sum c(5-i)*T_i(x)
	//   b(k) = c + 2x*b(k+1) - b(k+2), last step uses x instead of 2x

	lsp_pkg::fix_t [0:lsp_pkg::HALF_ORDER] c_r;  // Latched coefficients
	lsp_pkg::fix_t x_r;                          // Latched point
	lsp_pkg::fix_t b1;                           // b(k+1)
	lsp_pkg::fix_t b2;                           // b(k+2)
	lsp_pkg::fix_t mul_a;                        // Multiplier operand
	lsp_pkg::fix_t prod;
	lsp_pkg::fix_t b_new;
	logic [2:0]    k;                            // Coefficient index
	logic          busy;
	logic          go;
	logic          last;

	assign go   = eval_start && !busy;
	assign last = busy && (k == 3'(lsp_pkg::HALF_ORDER));

	// -------------------------------------------------------------------
	// One shared multiplier, one term per cycle
	// -------------------------------------------------------------------
	assign mul_a = last ? x_r : lsp_pkg::fix_double(x_r);
	assign prod  = lsp_pkg::fix_mul(mul_a, b1);
	assign b_new = lsp_pkg::fix_add(lsp_pkg::fix_add(c_r[k], prod), lsp_pkg::fix_neg(b2));

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			busy      <= 1'b0;
			k         <= 3'd0;
			eval_done <= 1'b0;
		end
		else
		begin
			eval_done <= last;                    // Six cycles after start
			if (go)
			begin
				busy <= 1'b1;
				k    <= 3'd1;                     // c0 consumed at start
			end
			else if (last)
			begin
				busy <= 1'b0;
				k    <= 3'd0;
			end
			else if (busy)
				k <= k + 3'd1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (go)
		begin
			x_r <= eval_x;
			c_r <= eval_coeffs;
			b1  <= eval_coeffs.c0;                // b5 = c0, since b6 = b7 = 0
			b2  <= lsp_pkg::FIX_ZERO;
		end
		else if (busy)
		begin
			b1 <= b_new;
			b2 <= b1;
			if (last)
				eval_sum <= b_new;                // Held until the next result
		end
	end

	// Requester must wait for eval_done before the next request
	a_no_overlap: assert property (@(posedge clk) disable iff (!rst)
		eval_start |-> !busy)
		else $error("cheb_eval: eval_start during a running evaluation");

endmodule

//--- root_search.sv
`timescale 1ns/1ps

module root_search #(
	parameter lsp_pkg::fix_t GRID_STEP    = 32'h0002_8F5C,  // About 0.01
	parameter int            BISECT_STEPS = 6
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  start,
	input  lsp_pkg::pq_coeffs_t   pq,
	input  logic                  pq_valid,
	output logic                  eval_start,
	output lsp_pkg::fix_t         eval_x,
	output lsp_pkg::cheb_coeffs_t eval_coeffs,
	input  lsp_pkg::fix_t         eval_sum,
	input  logic                  eval_done,
	output lsp_pkg::lsp_vec_t     lsp,
	output logic                  done
);

	localparam int BW = $clog2(BISECT_STEPS + 1);

	typedef enum logic [2:0] {S_IDLE, S_WAIT_PQ, S_ISSUE, S_WAIT, S_NEXT} state_t;
	typedef enum logic [1:0] {PH_BASE, PH_GRID, PH_BISECT} phase_t;

	state_t        state;
	phase_t        phase;
	logic [3:0]    idx;                           // Root index 0..9
	logic [BW-1:0] bis_cnt;
	lsp_pkg::fix_t x1;                            // Upper end of bracket
	lsp_pkg::fix_t xr;                            // Lower end of bracket
	lsp_pkg::fix_t x_base;                        // Last root found
	lsp_pkg::fix_t psum1;                         // Value at x1
	lsp_pkg::fix_t xr_next;
	lsp_pkg::fix_t xm;
	lsp_pkg::fix_t [0:lsp_pkg::ORDER-1] roots;
	logic          below;
	logic          changed;
	logic          roots_ok;

	// -------------------------------------------------------------------
	// Datapath
	// -------------------------------------------------------------------
	assign xr_next = lsp_pkg::fix_add(x1, lsp_pkg::fix_neg(GRID_STEP)); // One grid step down
	// Point fell below -1, comparator folded in
	assign below = (xr_next[lsp_pkg::MAG_W] == lsp_pkg::FIX_NEG_ONE[lsp_pkg::MAG_W]) &&
		(xr_next[lsp_pkg::MAG_W-1:0] > lsp_pkg::FIX_NEG_ONE[lsp_pkg::MAG_W-1:0]);
	assign xm      = lsp_pkg::fix_half(lsp_pkg::fix_add(x1, xr));  // Bracket midpoint
	assign changed = lsp_pkg::fix_sign_differs(eval_sum, psum1);
	assign eval_coeffs = idx[0] ? pq.q : pq.p;    // P on even roots, Q on odd
	assign lsp = lsp_pkg::lsp_vec_t'(roots);

	// -------------------------------------------------------------------
	// Search sequencer
	// -------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state      <= S_IDLE;
			phase      <= PH_BASE;
			idx        <= 4'd0;
			bis_cnt    <= '0;
			eval_start <= 1'b0;
			eval_x     <= lsp_pkg::FIX_ZERO;
			done       <= 1'b0;
			x1         <= lsp_pkg::FIX_ONE;
			xr         <= lsp_pkg::FIX_ZERO;
			x_base     <= lsp_pkg::FIX_ONE;
			psum1      <= lsp_pkg::FIX_ZERO;
			roots      <= '0;
		end
		else
		begin
			eval_start <= 1'b0;
			done       <= 1'b0;
			case (state)
				S_IDLE:
					if (start)
						state <= S_WAIT_PQ;
				S_WAIT_PQ:
					if (pq_valid)
					begin
						idx    <= 4'd0;
						x1     <= lsp_pkg::FIX_ONE;   // First search from +1
						x_base <= lsp_pkg::FIX_ONE;
						phase  <= PH_BASE;
						state  <= S_ISSUE;
					end
				S_ISSUE:
				begin
					eval_start <= 1'b1;
					state      <= S_WAIT;
					case (phase)
						PH_BASE:
							eval_x <= x1;
						PH_GRID:
							if (below)
							begin
								eval_start <= 1'b0;   // Root not found, keep old value
								state      <= S_NEXT;
							end
							else
							begin
								xr     <= xr_next;
								eval_x <= xr_next;
							end
						default:
							eval_x <= xm;
					endcase
				end
				S_WAIT:
					if (eval_done)
					begin
						state <= S_ISSUE;
						case (phase)
							PH_BASE:
							begin
								psum1 <= eval_sum;
								phase <= PH_GRID;
							end
							PH_GRID:
								if (changed)
								begin
									phase   <= PH_BISECT;   // Sign change inside [xr, x1]
									bis_cnt <= '0;
								end
								else
								begin
									x1    <= xr;
									psum1 <= eval_sum;
								end
							default:
							begin
								if (changed)
									xr <= eval_x;       // Root in upper half
								else
								begin
									x1    <= eval_x;
									psum1 <= eval_sum;
								end
								bis_cnt <= bis_cnt + 1'b1;
								if (bis_cnt == BW'(BISECT_STEPS - 1))
								begin
									roots[idx] <= eval_x;  // Last midpoint is the root
									x_base     <= eval_x;
									state      <= S_NEXT;
								end
							end
						endcase
					end
				S_NEXT:
					if (idx == 4'(lsp_pkg::ORDER - 1))
					begin
						done  <= 1'b1;
						state <= S_IDLE;
					end
					else
					begin
						idx   <= idx + 4'd1;
						x1    <= x_base;            // Restart from last root
						phase <= PH_BASE;
						state <= S_ISSUE;
					end
				default:
					state <= S_IDLE;
			endcase
		end
	end

	always_comb
	begin
		roots_ok = 1'b1;
		for (int i = 0; i < lsp_pkg::ORDER; i++)
			if (roots[i][lsp_pkg::MAG_W-1:0] > lsp_pkg::FIX_ONE[lsp_pkg::MAG_W-1:0])
				roots_ok = 1'b0;
	end

	a_done_pulse: assert property (@(posedge clk) disable iff (!rst) done |=> !done)
		else $error("root_search: done wider than one cycle");
	a_roots_range: assert property (@(posedge clk) disable iff (!rst) roots_ok)
		else $error("root_search: stored root outside -1..+1");

endmodule

//--- lsp_top.sv
`timescale 1ns/1ps

module lsp_top #(
	parameter lsp_pkg::fix_t GRID_STEP    = 32'h0002_8F5C,  // Search grid, about 0.01
	parameter int            BISECT_STEPS = 6               // Halvings per root
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 start,
	input  lsp_pkg::lpc_coeffs_t lpc,
	output lsp_pkg::lsp_vec_t    lsp,
	output logic                 done
);

	lsp_pkg::pq_coeffs_t   pq;                    // Doubled P and Q sets
	logic                  pq_valid;
	logic                  eval_start;
	logic                  eval_done;
	lsp_pkg::fix_t         eval_x;
	lsp_pkg::fix_t         eval_sum;
	lsp_pkg::cheb_coeffs_t eval_coeffs;

	// -------------------------------------------------------------------
	// Builder, shared evaluator, search
	// -------------------------------------------------------------------
	pq_builder i_pq_builder (
		.clk      (clk),
		.rst      (rst),
		.start    (start),
		.lpc      (lpc),
		.pq       (pq),
		.pq_valid (pq_valid)
	);

	cheb_eval i_cheb_eval (
		.clk         (clk),
		.rst         (rst),
		.eval_start  (eval_start),
		.eval_x      (eval_x),
		.eval_coeffs (eval_coeffs),
		.eval_sum    (eval_sum),
		.eval_done   (eval_done)
	);

	root_search #(
		.GRID_STEP    (GRID_STEP),
		.BISECT_STEPS (BISECT_STEPS)
	) i_root_search (
		.clk         (clk),
		.rst         (rst),
		.start       (start),
		.pq          (pq),
		.pq_valid    (pq_valid),
		.eval_start  (eval_start),
		.eval_x      (eval_x),
		.eval_coeffs (eval_coeffs),
		.eval_sum    (eval_sum),
		.eval_done   (eval_done),
		.lsp         (lsp),
		.done        (done)
	);

endmodule

//--- tb_lsp_top.sv
`timescale 1ns/1ps

module tb_lsp_top;

	// -------------------------------------------------------------------
	// Run limits and reference constants
	// -------------------------------------------------------------------
	localparam real    PI          = 3.14159265358979;
	localparam int     BISECT      = 6;                       // DUT default halvings
	localparam real    GRID        = 167772.0 / 16777216.0;   // 0x28F5C, about 0.01
	localparam real    ROUND_TOL   = 1.0 / 16384.0;           // Truncation slack
	localparam int     NUM_RAND    = 4;
	localparam int     FRAMES      = 1 + NUM_RAND + 3;        // Flat, random, restart sequence
	// Ten roots, 200 grid points plus base and halvings, 8 cycles per evaluation
	localparam int     FRAME_MAX   = lsp_pkg::ORDER * (200 + BISECT + 1) * 8 + 32;
	localparam longint WATCHDOG_NS = longint'(FRAMES * FRAME_MAX + 2000) * 20;

	logic                 clk;
	logic                 rst;
	logic                 start;
	lsp_pkg::lpc_coeffs_t lpc;
	lsp_pkg::lsp_vec_t    lsp;
	logic                 done;

	logic        started;                         // First start driven
	logic        frame_open;                      // Frame in flight
	int          done_count;
	int          errors;
	int          pulse_errors;
	int          tests_run;
	int          tests_failed;
	logic [31:0] lfsr_state;

	lsp_top i_lsp_top (
		.clk   (clk),
		.rst   (rst),
		.start (start),
		.lpc   (lpc),
		.lsp   (lsp),
		.done  (done)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;                   // 20 ns period
	end

	always @(posedge clk or negedge rst)
	begin
		if (!rst)
			done_count <= 0;
		else if (done)
			done_count <= done_count + 1;
	end

	// -------------------------------------------------------------------
	// Protocol checks, active over the whole run
	// -------------------------------------------------------------------
	a_reset_quiet: assert property (@(posedge clk) disable iff (!rst)
		!started |-> (!done && lsp == '0))
	else
	begin
		$display("[FAIL] reset_state: expected done=0 lsp=0, actual done=%b lsp=%h", done, lsp);
		errors++;
	end

	a_done_single: assert property (@(posedge clk) disable iff (!rst) done |=> !done)
	else
	begin
		$display("done stayed high for more than one cycle");
		errors++;
		pulse_errors++;
	end

	a_done_after_start: assert property (@(posedge clk) disable iff (!rst) done |-> frame_open)
	else
	begin
		$display("done arrived while no frame was running");
		errors++;
		pulse_errors++;
	end

	// -------------------------------------------------------------------
	// Stimulus helpers
	// -------------------------------------------------------------------
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // x^32+x^22+x^2+x+1
	endfunction

	function automatic logic take_bit();
		lfsr_state = lfsr_next(lfsr_state);       // One step per bit
		return lfsr_state[0];
	endfunction

	// Magnitude below 2^-7 keeps the filter near flat
	function automatic lsp_pkg::fix_t rand_coeff();
		logic        sgn;
		logic [16:0] mag;
		sgn = take_bit();
		for (int i = 0; i < 17; i++)
			mag[i] = take_bit();
		if (mag == '0)
			sgn = 1'b0;                           // No negative zero
		return {sgn, 14'd0, mag};
	endfunction

	function automatic lsp_pkg::lpc_coeffs_t flat_frame();
		lsp_pkg::fix_t [0:lsp_pkg::ORDER] a;
		a    = '0;
		a[0] = lsp_pkg::FIX_ONE;
		return lsp_pkg::lpc_coeffs_t'(a);
	endfunction

	function automatic lsp_pkg::lpc_coeffs_t random_frame();
		lsp_pkg::fix_t [0:lsp_pkg::ORDER] a;
		a[0] = lsp_pkg::FIX_ONE;
		for (int i = 1; i <= lsp_pkg::ORDER; i++)
			a[i] = rand_coeff();
		return lsp_pkg::lpc_coeffs_t'(a);
	endfunction

	function automatic real fix_to_real(input lsp_pkg::fix_t v);
		real m;
		m = real'(v[30:0]) / 16777216.0;          // 24 fraction bits
		return v[31] ? -m : m;
	endfunction

	task automatic start_frame(input lsp_pkg::lpc_coeffs_t f);
		@(posedge clk);
		lpc        <= f;                          // Held until the next frame
		start      <= 1'b1;
		started    <= 1'b1;
		frame_open <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
	endtask

	// Bare start pulse, lpc untouched
	task automatic pulse_start();
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
	endtask

	task automatic wait_done(input string name);
		int cycles;
		cycles = 0;
		while (!done && cycles < FRAME_MAX)
		begin
			@(posedge clk);
			cycles++;
		end
		if (done)
			frame_open <= 1'b0;
		else
		begin
			$display("%s: no done within %0d cycles of start", name, FRAME_MAX);
			errors++;
		end
	endtask

	task automatic finish_test(input string name, input int n_err);
		tests_run++;
		if (n_err == 0)
			$display("%-16s ok", name);
		else
		begin
			tests_failed++;
			$display("%-16s FAILED, %0d errors", name, n_err);
		end
	endtask

	// -------------------------------------------------------------------
	// Result checks
	// -------------------------------------------------------------------
	// Flat filter roots sit at cos((n+1)*pi/11)
	task automatic check_flat();
		lsp_pkg::fix_t [0:lsp_pkg::ORDER-1] r;
		real exp_v;
		real got_v;
		real tol;
		r   = lsp;
		tol = GRID / real'(1 << BISECT) + ROUND_TOL;
		for (int n = 0; n < lsp_pkg::ORDER; n++)
		begin
			exp_v = $cos(real'(n + 1) * PI / 11.0);
			got_v = fix_to_real(r[n]);
			assert (got_v - exp_v <= tol && exp_v - got_v <= tol)
			else
			begin
				$display("[FAIL] flat_filter lsp%0d: expected %.6f, actual %.6f",
					n, exp_v, got_v);
				errors++;
			end
		end
	endtask

	// Interleaved P and Q roots, strictly falling inside -1..+1
	task automatic check_ordered(input string name);
		lsp_pkg::fix_t [0:lsp_pkg::ORDER-1] r;
		real v;
		real prev;
		r    = lsp;
		prev = 2.0;
		for (int n = 0; n < lsp_pkg::ORDER; n++)
		begin
			v = fix_to_real(r[n]);
			assert (v >= -1.0 && v <= 1.0)
			else
			begin
				$display("[FAIL] %s lsp%0d range: expected -1..+1, actual %.6f", name, n, v);
				errors++;
			end
			assert (v < prev)
			else
			begin
				$display("[FAIL] %s lsp%0d order: expected below %.6f, actual %.6f",
					name, n, prev, v);
				errors++;
			end
			prev = v;
		end
	endtask

	// -------------------------------------------------------------------
	// Test sequence
	// -------------------------------------------------------------------
	initial
	begin
		lsp_pkg::lpc_coeffs_t frame;
		lsp_pkg::lsp_vec_t    clean;
		int                   err0;
		int                   dones0;
		rst          = 1'b0;
		start        = 1'b0;
		lpc          = '0;
		started      = 1'b0;
		frame_open   = 1'b0;
		errors       = 0;
		pulse_errors = 0;
		tests_run    = 0;
		tests_failed = 0;
		lfsr_state   = 32'h0000_fde1;
		repeat (3) @(posedge clk);
		rst <= 1'b1;

		err0 = errors;                            // Idle outputs before any start
		repeat (5) @(posedge clk);
		assert (!done && lsp == '0)
		else
		begin
			$display("[FAIL] reset_state: expected done=0 lsp=0, actual done=%b lsp=%h",
				done, lsp);
			errors++;
		end
		finish_test("reset_state", errors - err0);

		err0 = errors;
		start_frame(flat_frame());
		wait_done("flat_filter");
		check_flat();
		finish_test("flat_filter", errors - err0);

		err0 = errors;
		for (int f = 0; f < NUM_RAND; f++)
		begin
			start_frame(random_frame());
			wait_done("random_frames");
			check_ordered($sformatf("random_frames#%0d", f));
		end
		finish_test("random_frames", errors - err0);

		// Clean run and a flat frame before the same frame with stray starts
		err0  = errors;
		frame = random_frame();
		start_frame(frame);
		wait_done("restart_ignored");
		clean = lsp;
		start_frame(flat_frame());                // Moves lsp away from the clean roots
		wait_done("restart_ignored");
		repeat (10) @(posedge clk);
		dones0 = done_count;
		start_frame(frame);
		repeat (2) @(posedge clk);
		pulse_start();                            // Builder still busy
		repeat (150) @(posedge clk);
		pulse_start();                            // Search running
		wait_done("restart_ignored");
		repeat (100) @(posedge clk);
		assert (done_count - dones0 == 1)
		else
		begin
			$display("[FAIL] restart_ignored done count: expected 1, actual %0d",
				done_count - dones0);
			errors++;
		end
		assert (lsp == clean)
		else
		begin
			$display("[FAIL] restart_ignored lsp: expected %h, actual %h", clean, lsp);
			errors++;
		end
		finish_test("restart_ignored", errors - err0);

		finish_test("done_pulse", pulse_errors);

		$display("tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0 && tests_failed == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	// Hang guard sized from the frame count
	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
		$display("Test failed");
		$finish;
	end

endmodule

//--- build.f
lsp_pkg.sv
pq_builder.sv
cheb_eval.sv
root_search.sv
lsp_top.sv
tb_lsp_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_lsp_top
OBJ_DIR   ?= obj_dir
FILELIST  ?= build.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= Test passed

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
